//--- fetch_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch side widths, table and target buffer geometry
// fetch address, history, predicted slot and fetch bundle types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fetch_pkg;

  localparam int IP_W        = 32;
  localparam int GHT_W       = 16;
  localparam int BLOCK_BYTES = 16;
  localparam int OFFSET_W    = $clog2(BLOCK_BYTES);  // byte offset inside a block

  // target buffer, index from ip[11:4], tag from ip[31:12]
  localparam int TB_IDX_W   = 8;
  localparam int TB_TAG_W   = 20;
  localparam int TB_ENTRIES = 1 << TB_IDX_W;
  localparam int NUM_SLOTS  = 2;  // one way per branch slot

  // direction tables
  localparam int PRED_IDX_W   = 10;
  localparam int PRED_ENTRIES = 1 << PRED_IDX_W;
  localparam int PRED_TABLES  = 3;

  typedef logic [IP_W-1:0]  ip_t;
  typedef logic [GHT_W-1:0] ght_t;

  localparam ip_t RESET_IP = 32'h0000_1000;

  typedef enum logic [1:0] {
    SLOT_NONE = 2'd0,
    SLOT_0    = 2'd1,
    SLOT_1    = 2'd2
  } slot_e;

  // history snapshot rides along so the back end can hand it back at retire
  typedef struct packed {
    ip_t   ip;
    ght_t  ght;
    slot_e slot;
  } fetch_t;

endpackage

`default_nettype wire

//--- retire_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// retire bundle returned by the back end
// table select encoding used for mispredict training
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package retire_pkg;
  import fetch_pkg::*;

  typedef struct packed {
    logic valid;
    logic slot;        // branch slot within the fetch block
    logic taken;
    logic mispredict;
    ip_t  src_ip;      // block address the branch was fetched from
    ip_t  target;
    ght_t ght;         // history as seen at fetch
  } retire_t;

  // one table trains per mispredict, rotating a, b, c
  typedef enum logic [1:0] {
    TRAIN_A = 2'd0,
    TRAIN_B = 2'd1,
    TRAIN_C = 2'd2
  } train_sel_e;

endpackage

`default_nettype wire

//--- pred_tables.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pred_tables: three hashed direction tables, two bits per entry
// entries xor'ed into one taken bit per slot, rotating training
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pred_tables
  import fetch_pkg::*;
  import retire_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ip_t        cur_ip,
  input  ght_t       cur_ght,
  input  retire_t    retire,
  output logic [1:0] taken
);

  // each table trades address bits against history bits
  function automatic logic [PRED_IDX_W-1:0] pred_idx(
    input int unsigned t,
    input ip_t         ip,
    input ght_t        ght
  );
    case (t)
      0:       pred_idx = {ip[11:4], ght[1:0]};
      1:       pred_idx = {ip[8:4], ght[4:0]};
      default: pred_idx = {ip[5:4], ght[7:0]};
    endcase
  endfunction

  function automatic train_sel_e next_sel(input train_sel_e sel);
    case (sel)
      TRAIN_A: next_sel = TRAIN_B;
      TRAIN_B: next_sel = TRAIN_C;
      default: next_sel = TRAIN_A;
    endcase
  endfunction

  logic [PRED_TABLES-1:0][PRED_ENTRIES-1:0][1:0] tbl;
  logic [PRED_TABLES-1:0][1:0]                   rd;
  train_sel_e                                    train_sel;
  logic                                          trn_en;
  logic [PRED_IDX_W-1:0]                         trn_idx;

  // combinational read, writes show up next cycle
  always_comb begin
    taken = '0;
    for (int t = 0; t < PRED_TABLES; t++) begin
      rd[t] = tbl[t][pred_idx(t, cur_ip, cur_ght)];
      taken = taken ^ rd[t];
    end
  end

  assign trn_en  = retire.valid && retire.mispredict;
  assign trn_idx = pred_idx(train_sel, retire.src_ip, retire.ght);  // same hash as fetch

  always_ff @(posedge clk) begin
    if (rst) begin
      tbl       <= '0;
      train_sel <= TRAIN_A;
    end else if (trn_en) begin
      // flip only the mispredicted slot's bit
      tbl[train_sel][trn_idx][retire.slot] <= ~tbl[train_sel][trn_idx][retire.slot];
      train_sel <= next_sel(train_sel);
    end
  end

  a_train_sel_legal: assert property (
    @(posedge clk) disable iff (rst)
    train_sel inside {TRAIN_A, TRAIN_B, TRAIN_C}
  ) else $error("train_sel holds unused encoding %0d", train_sel);

endmodule

`default_nettype wire

//--- target_buffer.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// target_buffer: two-way tagged target store, one way per slot
// installs on retire, sticky flag for taken-but-missing ways
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module target_buffer
  import fetch_pkg::*;
  import retire_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ip_t        cur_ip,
  input  logic [1:0] taken,
  input  retire_t    retire,
  output logic [1:0] hit,
  output ip_t        target0,
  output ip_t        target1,
  output logic       tbuf_miss
);

  typedef struct packed {
    logic [TB_TAG_W-1:0] tag;
    ip_t                 target;
  } tb_entry_t;

  function automatic logic [TB_IDX_W-1:0] tb_idx(input ip_t ip);
    tb_idx = ip[OFFSET_W +: TB_IDX_W];
  endfunction

  function automatic logic [TB_TAG_W-1:0] tb_tag(input ip_t ip);
    tb_tag = ip[IP_W-1 -: TB_TAG_W];
  endfunction

  logic [NUM_SLOTS-1:0][TB_ENTRIES-1:0] tb_valid;
  tb_entry_t                            tb_mem [NUM_SLOTS][TB_ENTRIES];
  tb_entry_t                            rd_ent [NUM_SLOTS];
  tb_entry_t                            wr_ent;
  logic [TB_IDX_W-1:0]                  rd_idx;
  logic [TB_IDX_W-1:0]                  wr_idx;

  assign rd_idx = tb_idx(cur_ip);
  assign wr_idx = tb_idx(retire.src_ip);

  always_comb begin
    for (int w = 0; w < NUM_SLOTS; w++) begin
      rd_ent[w] = tb_mem[w][rd_idx];
      hit[w]    = tb_valid[w][rd_idx] && (rd_ent[w].tag == tb_tag(cur_ip));
    end
  end

  assign target0 = rd_ent[0].target;
  assign target1 = rd_ent[1].target;

  always_comb begin
    wr_ent.tag    = tb_tag(retire.src_ip);
    wr_ent.target = retire.target;
  end

  always_ff @(posedge clk) begin
    if (retire.valid) tb_mem[retire.slot][wr_idx] <= wr_ent;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tb_valid  <= '0;
      tbuf_miss <= 1'b0;
    end else begin
      if (retire.valid) tb_valid[retire.slot][wr_idx] <= 1'b1;
      if (|(taken & ~hit)) tbuf_miss <= 1'b1;  // stays set until reset
    end
  end

  // whatever retire installed must still come out block aligned
  a_way0_aligned: assert property (
    @(posedge clk) disable iff (rst) hit[0] |-> target0[OFFSET_W-1:0] == '0
  ) else $error("way 0 target %h not block aligned", target0);

  a_way1_aligned: assert property (
    @(posedge clk) disable iff (rst) hit[1] |-> target1[OFFSET_W-1:0] == '0
  ) else $error("way 1 target %h not block aligned", target1);

endmodule

`default_nettype wire

//--- fetch_sequencer.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_sequencer: fetch address and global history registers
// slot pick, next address choice, mispredict recovery
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_sequencer
  import fetch_pkg::*;
  import retire_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] taken,
  input  logic [1:0] hit,
  input  ip_t        target0,
  input  ip_t        target1,
  input  retire_t    retire,
  input  logic       fetch_ready,
  output fetch_t     fetch,
  output logic       fetch_valid,
  output ip_t        cur_ip,
  output ght_t       cur_ght
);

  // slot 0 taken adds a single 1, slot 1 taken adds 0 then 1
  function automatic ght_t shift_ght(input ght_t g, input slot_e s);
    case (s)
      SLOT_0:  shift_ght = {g[GHT_W-2:0], 1'b1};
      SLOT_1:  shift_ght = {g[GHT_W-3:0], 2'b01};
      default: shift_ght = {g[GHT_W-3:0], 2'b00};
    endcase
  endfunction

  ip_t   ip_q;
  ght_t  ght_q;
  logic  valid_q;
  slot_e slot;
  ip_t   pred_ip;
  ght_t  pred_ght;
  slot_e rec_slot;
  ip_t   rec_ip;
  ght_t  rec_ght;
  logic  accept;
  logic  redirect;

  // prediction path
  always_comb begin
    if (taken[0] && hit[0]) slot = SLOT_0;
    else if (taken[1] && hit[1]) slot = SLOT_1;
    else slot = SLOT_NONE;

    case (slot)
      SLOT_0:  pred_ip = target0;
      SLOT_1:  pred_ip = target1;
      default: pred_ip = ip_q + ip_t'(BLOCK_BYTES);  // fall through
    endcase
    pred_ght = shift_ght(ght_q, slot);
  end

  // recovery path, history rebuilt from the fetch-time snapshot
  always_comb begin
    if (!retire.taken) rec_slot = SLOT_NONE;
    else if (retire.slot) rec_slot = SLOT_1;
    else rec_slot = SLOT_0;

    rec_ip  = retire.taken ? retire.target : retire.src_ip + ip_t'(BLOCK_BYTES);
    rec_ght = shift_ght(retire.ght, rec_slot);
  end

  assign accept   = valid_q && fetch_ready;
  assign redirect = retire.valid && retire.mispredict;

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= RESET_IP;
      ght_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (redirect) begin  // wins over a same-cycle advance
        ip_q  <= rec_ip;
        ght_q <= rec_ght;
      end else if (accept) begin
        ip_q  <= pred_ip;
        ght_q <= pred_ght;
      end
    end
  end

  always_comb begin
    fetch.ip   = ip_q;
    fetch.ght  = ght_q;
    fetch.slot = slot;
  end

  assign fetch_valid = valid_q;
  assign cur_ip      = ip_q;
  assign cur_ght     = ght_q;

  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    fetch_valid && !fetch_ready && !redirect |=> $stable(ip_q) && $stable(ght_q)
  ) else $error("fetch bundle changed while stalled");

endmodule

`default_nettype wire

//--- fetch_predictor.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_predictor: next-fetch-address predictor top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_predictor
  import fetch_pkg::*;
  import retire_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  output fetch_t  fetch,
  output logic    fetch_valid,
  input  logic    fetch_ready,
  input  retire_t retire,
  output logic    tbuf_miss
);

  ip_t        cur_ip;
  ght_t       cur_ght;
  logic [1:0] taken;
  logic [1:0] hit;
  ip_t        target0;
  ip_t        target1;

  pred_tables pred_tables_i (
    .clk     (clk),
    .rst     (rst),
    .cur_ip  (cur_ip),
    .cur_ght (cur_ght),
    .retire  (retire),
    .taken   (taken)
  );

  target_buffer target_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .cur_ip    (cur_ip),
    .taken     (taken),
    .retire    (retire),
    .hit       (hit),
    .target0   (target0),
    .target1   (target1),
    .tbuf_miss (tbuf_miss)
  );

  fetch_sequencer fetch_sequencer_i (
    .clk         (clk),
    .rst         (rst),
    .taken       (taken),
    .hit         (hit),
    .target0     (target0),
    .target1     (target1),
    .retire      (retire),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .cur_ip      (cur_ip),
    .cur_ght     (cur_ght)
  );

endmodule

`default_nettype wire

//--- fetch_checker.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_checker: reference model of the fetch predictor,
// per-cycle compare of the fetch bundle, error counts, cycle limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_checker
  import fetch_pkg::*;
  import retire_pkg::*;
#(
  parameter int MAX_CYCLES = 2000
) (
  input  logic    clk,
  input  logic    rst,
  input  fetch_t  fetch,
  input  logic    fetch_valid,
  input  logic    fetch_ready,
  input  retire_t retire,
  input  logic    tbuf_miss,
  output int      mismatch_count,
  output int      fail_count,
  output logic    timed_out
);

  typedef struct packed {
    fetch_t bundle;    // what the dut should show now
    ip_t    next_ip;   // address after an accepted fetch
    ght_t   next_ght;
    logic   miss;      // taken slot without a matching way
  } expect_t;

  logic [1:0]          m_tbl [3][PRED_ENTRIES];
  int                  m_sel;
  logic                m_tv  [2][TB_ENTRIES];
  logic [TB_TAG_W-1:0] m_tag [2][TB_ENTRIES];
  ip_t                 m_tgt [2][TB_ENTRIES];
  ip_t                 m_ip;
  ght_t                m_ght;
  logic                m_valid;
  logic                m_miss;
  int                  cycle_count = 0;
  int                  n_mismatch = 0;
  int                  n_fail = 0;
  logic                timeout_hit = 1'b0;

  assign mismatch_count = n_mismatch;
  assign fail_count     = n_fail;
  assign timed_out      = timeout_hit;

  function automatic logic [PRED_IDX_W-1:0] table_index(input int t, input ip_t ip,
                                                         input ght_t g);
    if (t == 0) return {ip[11:4], g[1:0]};
    if (t == 1) return {ip[8:4], g[4:0]};
    return {ip[5:4], g[7:0]};
  endfunction

  function automatic ght_t history_after(input ght_t g, input slot_e s);
    if (s == SLOT_0) return {g[GHT_W-2:0], 1'b1};
    if (s == SLOT_1) return {g[GHT_W-3:0], 2'b01};
    return {g[GHT_W-3:0], 2'b00};
  endfunction

  // reference prediction from the model state
  function automatic expect_t predict_next(input ip_t ip, input ght_t g);
    expect_t             e;
    logic [1:0]          tk;
    logic [1:0]          ht;
    logic [TB_IDX_W-1:0] bi;
    tk = 2'b00;
    bi = ip[11:4];
    for (int t = 0; t < 3; t++) begin
      tk = tk ^ m_tbl[t][table_index(t, ip, g)];
    end
    for (int w = 0; w < 2; w++) begin
      ht[w] = m_tv[w][bi] && (m_tag[w][bi] == ip[31:12]);
    end
    e.bundle.ip  = ip;
    e.bundle.ght = g;
    if (tk[0] && ht[0]) begin
      e.bundle.slot = SLOT_0;
      e.next_ip     = m_tgt[0][bi];
    end else if (tk[1] && ht[1]) begin
      e.bundle.slot = SLOT_1;
      e.next_ip     = m_tgt[1][bi];
    end else begin
      e.bundle.slot = SLOT_NONE;
      e.next_ip     = ip + ip_t'(BLOCK_BYTES);
    end
    e.next_ght = history_after(g, e.bundle.slot);
    e.miss     = |(tk & ~ht);
    return e;
  endfunction

  task automatic reset_model();
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < PRED_ENTRIES; i++) m_tbl[t][i] = 2'b00;
    end
    for (int w = 0; w < 2; w++) begin
      for (int i = 0; i < TB_ENTRIES; i++) m_tv[w][i] = 1'b0;
    end
    m_sel   = 0;
    m_ip    = RESET_IP;
    m_ght   = '0;
    m_valid = 1'b0;
    m_miss  = 1'b0;
  endtask

  task automatic advance_model(input expect_t e);
    logic [PRED_IDX_W-1:0] ti;
    logic [TB_IDX_W-1:0]   bi;
    slot_e                 rs;
    bi = retire.src_ip[11:4];
    if (e.miss) m_miss = 1'b1;
    if (retire.valid && retire.mispredict) begin
      ti = table_index(m_sel, retire.src_ip, retire.ght);
      m_tbl[m_sel][ti][retire.slot] = ~m_tbl[m_sel][ti][retire.slot];
      m_sel = (m_sel + 1) % 3;
    end
    if (retire.valid) begin
      m_tv[retire.slot][bi]  = 1'b1;
      m_tag[retire.slot][bi] = retire.src_ip[31:12];
      m_tgt[retire.slot][bi] = retire.target;
    end
    if (retire.valid && retire.mispredict) begin
      if (!retire.taken) rs = SLOT_NONE;
      else if (retire.slot) rs = SLOT_1;
      else rs = SLOT_0;
      m_ip  = retire.taken ? retire.target : retire.src_ip + ip_t'(BLOCK_BYTES);
      m_ght = history_after(retire.ght, rs);
    end else if (m_valid && fetch_ready) begin
      m_ip  = e.next_ip;
      m_ght = e.next_ght;
    end
    m_valid = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      n_mismatch++;
    end
  endtask

  // outputs are read before this edge's register updates land
  always @(posedge clk) begin
    expect_t now_exp;
    cycle_count++;
    if (cycle_count == MAX_CYCLES) begin
      $display("timeout: run reached the limit of %0d cycles", MAX_CYCLES);
      n_fail++;
      timeout_hit = 1'b1;
    end
    if (rst) begin
      if (fetch_valid === 1'b1) begin
        $display("fetch_valid is high during reset at %0t", $time);
        n_fail++;
      end
      if (tbuf_miss === 1'b1 && m_valid === 1'b0) begin
        $display("tbuf_miss is still set during reset at %0t", $time);
        n_fail++;
      end
      reset_model();
    end else begin
      now_exp = predict_next(m_ip, m_ght);
      check_value("fetch_valid", 32'(fetch_valid), 32'(m_valid));
      check_value("tbuf_miss", 32'(tbuf_miss), 32'(m_miss));
      if (m_valid) begin
        check_value("fetch.ip", fetch.ip, now_exp.bundle.ip);
        check_value("fetch.ght", 32'(fetch.ght), 32'(now_exp.bundle.ght));
        check_value("fetch.slot", 32'(fetch.slot), 32'(now_exp.bundle.slot));
      end
      advance_model(now_exp);
    end
  end

endmodule

`default_nettype wire

//--- tb_fetch_predictor.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock, reset, directed and random stimulus
// DUT and checker instances, closing report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_fetch_predictor
  import fetch_pkg::*;
  import retire_pkg::*;
();

  localparam int RESET_CYCLES  = 3;
  localparam int DIRECTED_MAX  = 197;  // bound on the directed part
  localparam int RANDOM_CYCLES = 1300;
  localparam int TEST_CYCLES   = RESET_CYCLES + DIRECTED_MAX + RANDOM_CYCLES;
  localparam int MAX_CYCLES    = TEST_CYCLES + TEST_CYCLES / 3;

  localparam ip_t X_IP  = 32'h0000_1040;
  localparam ip_t T_IP  = 32'h0000_1200;
  localparam ip_t Y_IP  = 32'h0000_1080;
  localparam ip_t T0_IP = 32'h0000_1400;
  localparam ip_t T1_IP = 32'h0000_1300;
  localparam ip_t Z_IP  = 32'h0010_1080;  // same buffer index as Y but another tag

  logic    clk;
  logic    rst;
  fetch_t  fetch;
  logic    fetch_valid;
  logic    fetch_ready;
  retire_t retire;
  logic    tbuf_miss;
  int      mismatch_count;
  int      fail_count;
  logic    timed_out;
  int      wait_errors = 0;
  fetch_t  seen_q [$];  // accepted bundles feed the retires

  fetch_predictor dut_i (
    .clk         (clk),
    .rst         (rst),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .retire      (retire),
    .tbuf_miss   (tbuf_miss)
  );

  fetch_checker #(.MAX_CYCLES(MAX_CYCLES)) checker_i (
    .clk            (clk),
    .rst            (rst),
    .fetch          (fetch),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .retire         (retire),
    .tbuf_miss      (tbuf_miss),
    .mismatch_count (mismatch_count),
    .fail_count     (fail_count),
    .timed_out      (timed_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst && fetch_valid && fetch_ready) begin
      seen_q.push_back(fetch);
      if (seen_q.size() > 32) void'(seen_q.pop_front());
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_retire(input logic slot, input logic taken, input logic mispredict,
                             input ip_t src, input ip_t target, input ght_t ght);
    retire.valid      = 1'b1;
    retire.slot       = slot;
    retire.taken      = taken;
    retire.mispredict = mispredict;
    retire.src_ip     = src;
    retire.target     = target;
    retire.ght        = ght;
    next_cycle();
    retire = '0;
  endtask

  task automatic wait_for_fetch(input ip_t ip, input int limit);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(posedge clk);
      seen = fetch_valid && fetch_ready && fetch.ip == ip;
      #1;
    end
    if (!seen) begin
      $display("fetch of address %h not seen within %0d cycles", ip, limit);
      wait_errors++;
    end
  endtask

  function automatic ip_t random_target();
    logic [31:0] r;
    ip_t         base;
    r    = $urandom;
    base = (r[9:8] == 2'b00) ? 32'h0010_1000 : RESET_IP;
    return base + ip_t'({r[5:0], 4'h0});  // block aligned
  endfunction

  task automatic random_cycle();
    logic [31:0] r;
    fetch_t      src;
    fetch_ready = ($urandom % 100) < 70;
    retire = '0;
    if (($urandom % 4) == 0 && seen_q.size() > 0) begin
      src = seen_q[$urandom % seen_q.size()];
      r   = $urandom;
      retire.valid      = 1'b1;
      retire.slot       = r[0];
      retire.taken      = r[1];
      retire.mispredict = r[3:2] == 2'b00;
      retire.src_ip     = src.ip;
      retire.ght        = src.ght;
      retire.target     = random_target();
    end
    next_cycle();
  endtask

  task automatic finish_run();
    $display("checks done: %0d mismatches, %0d other failures",
             mismatch_count, fail_count + wait_errors);
    if (mismatch_count == 0 && fail_count == 0 && wait_errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'hf05b));
    rst         = 1'b1;
    fetch_ready = 1'b0;
    retire      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst         = 1'b0;
    fetch_ready = 1'b1;
    wait_for_fetch(RESET_IP + 32'h80, 20);  // plain stepping with zero history

    // install, then train slot 0 at X and come back to X
    send_retire(1'b0, 1'b1, 1'b0, X_IP, T_IP, '0);
    send_retire(1'b0, 1'b1, 1'b1, X_IP, T_IP, '0);
    wait_for_fetch(T_IP, 4);
    send_retire(1'b1, 1'b0, 1'b1, X_IP - 32'h10, 32'h0000_1500, '0);
    wait_for_fetch(X_IP, 4);
    wait_for_fetch(T_IP, 4);

    // both slots taken and hit at Y
    send_retire(1'b1, 1'b1, 1'b0, Y_IP, T1_IP, '0);
    send_retire(1'b0, 1'b1, 1'b0, Y_IP, T0_IP, '0);
    send_retire(1'b0, 1'b1, 1'b1, Y_IP, T0_IP, '0);
    send_retire(1'b1, 1'b1, 1'b1, Y_IP, T1_IP, '0);
    send_retire(1'b0, 1'b0, 1'b1, Y_IP - 32'h10, T0_IP, '0);
    wait_for_fetch(Y_IP, 4);
    wait_for_fetch(T0_IP, 4);

    // tag miss at Z falls through
    send_retire(1'b1, 1'b0, 1'b1, Z_IP - 32'h10, 32'h0000_1600, '0);
    wait_for_fetch(Z_IP, 4);
    wait_for_fetch(Z_IP + 32'h10, 4);

    // recovery while stalled
    fetch_ready = 1'b0;
    send_retire(1'b0, 1'b1, 1'b1, Z_IP, T_IP, 16'h00a5);
    repeat (3) next_cycle();
    fetch_ready = 1'b1;
    wait_for_fetch(T_IP, 4);
    fetch_ready = 1'b0;
    send_retire(1'b1, 1'b0, 1'b1, Y_IP, T0_IP, 16'h0003);
    next_cycle();
    fetch_ready = 1'b1;
    wait_for_fetch(Y_IP + 32'h10, 4);

    repeat (RANDOM_CYCLES) begin
      if (!timed_out) random_cycle();
    end
    retire = '0;
    finish_run();
  end

  initial begin
    wait (timed_out === 1'b1);
    finish_run();
  end

endmodule

`default_nettype wire

//--- build.f
fetch_pkg.sv
retire_pkg.sv
pred_tables.sv
target_buffer.sv
fetch_sequencer.sv
fetch_predictor.sv
fetch_checker.sv
tb_fetch_predictor.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_predictor
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
